// File: src.f
hw/cva6_trace_pkg.sv
hw/snoop_reg_pkg.sv
hw/trace_buf_if.sv
hw/cfi_trace_pack.sv
hw/trace_fifo.sv
hw/snoop_ctrl.sv
hw/cfi_snooper_top.sv
verification/tb_cfi_snooper.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert --top-module tb_cfi_snooper \
        -f src.f -Mdir obj_dir && ./obj_dir/Vtb_cfi_snooper 2>&1) || {
  echo "$out"
  exit 1
}
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1

// File: verification/tb_cfi_snooper.sv
// Testbench for the trace snooper with stimulus, reference record model, compare tasks and tests
`timescale 1ns/1ns

module tb_cfi_snooper
  import cva6_trace_pkg::*;
  import snoop_reg_pkg::*;
();

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 40;

  logic                                clk;
  logic                                rst_n;
  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  src_pc;
  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  dst_pc;
  ctr_type_t [NUM_CORES-1:0]           ctr_type;
  priv_lvl_t [NUM_CORES-1:0]           priv_lvl;
  logic [NUM_CORES-1:0][31:0]          instr;
  logic [NUM_CORES-1:0]                pc_valid;
  logic                                reg_req;
  logic                                reg_we;
  reg_addr_t                           reg_addr;
  reg_data_t                           reg_wdata;
  reg_data_t                           reg_rdata;
  logic                                wm_irq;
  logic                                trig_irq;

  // Staged trace, applied to one core by push_trace
  logic [PC_WIDTH-1:0]  t_src;
  logic [PC_WIDTH-1:0]  t_dst;
  ctr_type_t            t_ctr;
  priv_lvl_t            t_priv;
  logic [31:0]          t_instr;
  logic [31:0]          rng;
  trace_rec_u           exp_q[$];
  int                   errors;
  int                   test_err_base;
  int                   tests_pass;
  int                   tests_fail;

  cfi_snooper_top #(.DEPTH(DEPTH)) DUT (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .src_pc_i        (src_pc),
    .dst_pc_i        (dst_pc),
    .ctr_type_i      (ctr_type),
    .priv_lvl_i      (priv_lvl),
    .instr_i         (instr),
    .pc_valid_i      (pc_valid),
    .reg_req_i       (reg_req),
    .reg_we_i        (reg_we),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_rdata_o     (reg_rdata),
    .watermark_irq_o (wm_irq),
    .trigger_irq_o   (trig_irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // PC halves drop bit 63 and bit 0, small fields are zero-extended
  function automatic trace_rec_u pack_ref(input logic [PC_WIDTH-1:0] src,
                                          input logic [PC_WIDTH-1:0] dst,
                                          input ctr_type_t ctr, input priv_lvl_t priv,
                                          input logic [31:0] ins);
    trace_rec_u r;
    r.f.pc_src_h = {1'b0, src[62:32]};
    r.f.pc_src_l = {src[31:1], 1'b0};
    r.f.pc_dst_h = {1'b0, dst[62:32]};
    r.f.pc_dst_l = {dst[31:1], 1'b0};
    r.f.metadata = {28'd0, ctr};
    r.f.opcode   = ins;
    r.f.priv     = {30'd0, priv};
    return r;
  endfunction

  task automatic check_word(input string name, input reg_data_t exp_v, input reg_data_t act);
    if (act !== exp_v) begin
      $display("ERR %s expected %h actual %h", name, exp_v, act);
      errors++;
    end
  endtask

  task automatic check_irq(input string name, input logic exp_v, input logic act);
    if (act !== exp_v) begin
      $display("ERR %s expected %h actual %h", name, exp_v, act);
      errors++;
    end
  endtask

  // --------------------
  // Register port
  // --------------------
  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    reg_req   = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_req   = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk);
    reg_req  = 1'b1;
    reg_we   = 1'b0;
    reg_addr = addr;
    @(negedge clk);
    reg_req  = 1'b0;
    data     = reg_rdata;
  endtask

  // Trace stimulus
  task automatic gen_trace();
    rng = xorshift(rng);
    t_src[63:32] = rng;
    rng = xorshift(rng);
    t_src[31:0] = rng;
    rng = xorshift(rng);
    t_dst[63:32] = rng;
    rng = xorshift(rng);
    t_dst[31:0] = rng;
    rng = xorshift(rng);
    t_instr = rng;
    t_ctr   = rng[7:4];
    t_priv  = rng[9:8];
  endtask

  task automatic push_trace(input logic core, input logic valid);
    @(negedge clk);
    src_pc[core]   = t_src;
    dst_pc[core]   = t_dst;
    ctr_type[core] = t_ctr;
    priv_lvl[core] = t_priv;
    instr[core]    = t_instr;
    pc_valid       = '0;
    pc_valid[core] = valid;
  endtask

  task automatic idle_trace();
    @(negedge clk);
    pc_valid = '0;
  endtask

  task automatic send_staged(input logic core);
    push_trace(core, 1'b1);
    idle_trace();
    exp_q.push_back(pack_ref(t_src, t_dst, t_ctr, t_priv, t_instr));
  endtask

  task automatic send_one(input logic core);
    gen_trace();
    send_staged(core);
  endtask

  task automatic settle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // --------------------
  // Waits and readback
  // --------------------
  task automatic wait_count(input int n);
    reg_data_t st;
    int        tries;
    logic      seen;
    seen = 1'b0;
    for (tries = 0; tries < TIMEOUT && !seen; tries++) begin
      reg_read(ADDR_STATUS, st);
      if (st[7:0] == 8'(n)) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("Timeout while waiting for the fill count to reach %0d", n);
      errors++;
    end
  endtask

  task automatic wait_irq(input logic use_trig, input logic level, input string name);
    int   tries;
    logic cur;
    logic seen;
    seen = 1'b0;
    for (tries = 0; tries < TIMEOUT && !seen; tries++) begin
      @(negedge clk);
      cur = use_trig ? trig_irq : wm_irq;
      if (cur === level) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      $display("Timeout while waiting for %s to go to %0d", name, level);
      errors++;
    end
  endtask

  // Head record against the oldest expected record, then pop it
  task automatic read_check_pop();
    trace_rec_u exp_rec;
    reg_data_t  w;
    if (exp_q.size() == 0) begin
      $display("Record readback with no expected record left");
      errors++;
    end else begin
      exp_rec = exp_q.pop_front();
      for (int i = 0; i < REC_WORDS; i++) begin
        reg_read(ADDR_REC_BASE + reg_addr_t'(4 * i), w);
        check_word($sformatf("rec_word[%0d]", i), exp_rec.w[i[2:0]], w);
      end
      reg_write(ADDR_POP, '0);
    end
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == test_err_base) begin
      $display("Test %0d %s: PASS", num, name);
      tests_pass++;
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", num, name, errors - test_err_base);
      tests_fail++;
    end
    test_err_base = errors;
  endtask

  initial begin
    reg_data_t           st;
    trace_rec_u          rec;
    logic [PC_WIDTH-1:0] match_dst;
    rng           = 32'd23;
    errors        = 0;
    test_err_base = 0;
    tests_pass    = 0;
    tests_fail    = 0;
    rst_n         = 1'b0;
    src_pc        = '0;
    dst_pc        = '0;
    ctr_type      = '0;
    priv_lvl      = '0;
    instr         = '0;
    pc_valid      = '0;
    reg_req       = 1'b0;
    reg_we        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    t_src         = '0;
    t_dst         = '0;
    t_ctr         = '0;
    t_priv        = '0;
    t_instr       = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Single capture from core 0
    send_one(1'b0);
    wait_count(1);
    read_check_pop();
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h0, st);
    end_test(1, "capture core 0");

    // Core 1 selected, core 0 ignored
    reg_write(ADDR_CTRL, 32'h1);
    gen_trace();
    push_trace(1'b0, 1'b1);
    idle_trace();
    settle(4);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h0, st);
    send_one(1'b1);
    wait_count(1);
    read_check_pop();
    end_test(2, "core select");

    // Invalid traces leave the count alone
    send_one(1'b1);
    wait_count(1);
    repeat (3) begin
      gen_trace();
      push_trace(1'b1, 1'b0);
    end
    idle_trace();
    settle(4);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h1, st);
    read_check_pop();
    end_test(3, "valid low");

    // Ten back to back, last two dropped
    reg_write(ADDR_CTRL, 32'h0);
    for (int i = 0; i < 10; i++) begin
      gen_trace();
      push_trace(1'b0, 1'b1);
      if (i < DEPTH) begin
        exp_q.push_back(pack_ref(t_src, t_dst, t_ctr, t_priv, t_instr));
      end
    end
    idle_trace();
    wait_count(DEPTH);
    settle(2);
    reg_read(ADDR_STATUS, st);
    check_word("status", (32'h1 << STAT_OVF_BIT) | 32'(DEPTH), st);
    repeat (DEPTH) read_check_pop();
    reg_write(ADDR_IRQ_CLR, 32'h2);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h0, st);
    end_test(4, "overflow");

    reg_write(ADDR_WATERMARK, 32'd3);
    send_one(1'b0);
    send_one(1'b0);
    wait_count(2);
    settle(2);
    check_irq("watermark_irq_o", 1'b0, wm_irq);
    send_one(1'b0);
    wait_irq(1'b0, 1'b1, "watermark_irq_o");
    read_check_pop();
    wait_irq(1'b0, 1'b0, "watermark_irq_o");
    reg_write(ADDR_WATERMARK, 32'd0);
    send_one(1'b0);
    wait_count(3);
    settle(2);
    check_irq("watermark_irq_o", 1'b0, wm_irq);
    repeat (3) read_check_pop();
    end_test(5, "watermark");

    // Trigger on the low target word of a staged trace
    gen_trace();
    match_dst = t_dst;
    rec = pack_ref(t_src, t_dst, t_ctr, t_priv, t_instr);
    reg_write(ADDR_TRIG_PC, rec.f.pc_dst_l);
    reg_write(ADDR_CTRL, 32'h2);
    send_staged(1'b0);
    wait_irq(1'b1, 1'b1, "trigger_irq_o");
    wait_count(1);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h201, st);
    gen_trace();
    t_dst[1] = ~match_dst[1];
    send_staged(1'b0);
    wait_count(2);
    check_irq("trigger_irq_o", 1'b1, trig_irq);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h202, st);
    reg_write(ADDR_IRQ_CLR, 32'h1);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h002, st);
    check_irq("trigger_irq_o", 1'b0, trig_irq);
    // Enabled trigger, different target word
    gen_trace();
    t_dst[1] = ~match_dst[1];
    send_staged(1'b0);
    wait_count(3);
    settle(2);
    check_irq("trigger_irq_o", 1'b0, trig_irq);
    reg_write(ADDR_CTRL, 32'h0);
    gen_trace();
    t_dst = match_dst;
    send_staged(1'b0);
    wait_count(4);
    settle(2);
    check_irq("trigger_irq_o", 1'b0, trig_irq);
    reg_read(ADDR_STATUS, st);
    check_word("status", 32'h004, st);
    repeat (4) read_check_pop();
    end_test(6, "trigger");

    $display("Tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hw/cfi_snooper_top.sv
// Top level of the trace snooper with plain trace and register ports
`timescale 1ns/1ns

module cfi_snooper_top
  import cva6_trace_pkg::*;
  import snoop_reg_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Per-core branch trace
  input  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  src_pc_i,
  input  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  dst_pc_i,
  input  ctr_type_t [NUM_CORES-1:0]           ctr_type_i,
  input  priv_lvl_t [NUM_CORES-1:0]           priv_lvl_i,
  input  logic [NUM_CORES-1:0][31:0]          instr_i,
  input  logic [NUM_CORES-1:0]                pc_valid_i,
  // Register port
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  reg_addr_t                           reg_addr_i,
  input  reg_data_t                           reg_wdata_i,
  output reg_data_t                           reg_rdata_o,
  // Interrupts
  output logic                                watermark_irq_o,
  output logic                                trigger_irq_o
);

  logic      core_sel;
  logic      trig_en;
  reg_data_t trig_pc;
  logic      trig_hit;
  logic      ovf_clr;

  trace_buf_if #(.DEPTH(DEPTH)) buf_if ();

  cfi_trace_pack u_pack (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .src_pc_i   (src_pc_i),
    .dst_pc_i   (dst_pc_i),
    .ctr_type_i (ctr_type_i),
    .priv_lvl_i (priv_lvl_i),
    .instr_i    (instr_i),
    .pc_valid_i (pc_valid_i),
    .core_sel_i (core_sel),
    .trig_en_i  (trig_en),
    .trig_pc_i  (trig_pc),
    .trig_hit_o (trig_hit),
    .buf_o      (buf_if.wr)
  );

  trace_fifo #(.DEPTH(DEPTH)) u_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ovf_clr_i (ovf_clr),
    .buf_i     (buf_if.store)
  );

  snoop_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .reg_req_i       (reg_req_i),
    .reg_we_i        (reg_we_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .core_sel_o      (core_sel),
    .trig_en_o       (trig_en),
    .trig_pc_o       (trig_pc),
    .trig_hit_i      (trig_hit),
    .ovf_clr_o       (ovf_clr),
    .buf_i           (buf_if.rd),
    .watermark_irq_o (watermark_irq_o),
    .trigger_irq_o   (trigger_irq_o)
  );

endmodule

// File: hw/snoop_ctrl.sv
// Register file, record read window, pop strobe and the two interrupt outputs
`timescale 1ns/1ns

module snoop_ctrl
  import cva6_trace_pkg::*;
  import snoop_reg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        reg_req_i,
  input  logic        reg_we_i,
  input  reg_addr_t   reg_addr_i,
  input  reg_data_t   reg_wdata_i,
  output reg_data_t   reg_rdata_o,
  output logic        core_sel_o,
  output logic        trig_en_o,
  output reg_data_t   trig_pc_o,
  input  logic        trig_hit_i,
  output logic        ovf_clr_o,
  trace_buf_if.rd     buf_i,
  output logic        watermark_irq_o,
  output logic        trigger_irq_o
);

  logic        wr_en;
  logic        rd_en;
  logic        sel_q;
  logic        trig_en_q;
  reg_data_t   wm_q;
  reg_data_t   trig_pc_q;
  logic        trig_flag_q;
  logic        wm_irq_q;
  reg_data_t   rdata_q;
  reg_data_t   rd_word;
  reg_addr_t   rec_off;
  logic        in_rec;
  logic        clr_hit;

  assign wr_en   = reg_req_i && reg_we_i;
  assign rd_en   = reg_req_i && !reg_we_i;
  assign clr_hit = wr_en && (reg_addr_i == ADDR_IRQ_CLR);

  // --------------------
  // Write decode
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q     <= 1'b0;
      trig_en_q <= 1'b0;
      wm_q      <= '0;
      trig_pc_q <= '0;
    end else if (wr_en) begin
      case (reg_addr_i)
        ADDR_CTRL: begin
          sel_q     <= reg_wdata_i[CTRL_SEL_BIT];
          trig_en_q <= reg_wdata_i[CTRL_TRIG_EN_BIT];
        end
        ADDR_WATERMARK: wm_q      <= reg_wdata_i;
        ADDR_TRIG_PC:   trig_pc_q <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Pop and overflow clear act at the edge that samples the write
  assign buf_i.pop = wr_en && (reg_addr_i == ADDR_POP);
  assign ovf_clr_o = clr_hit && reg_wdata_i[CLR_OVF_BIT];

  // --------------------
  // Read path
  // --------------------
  assign rec_off = reg_addr_i - ADDR_REC_BASE;
  assign in_rec  = (reg_addr_i >= ADDR_REC_BASE) && (rec_off[7:2] < 6'(REC_WORDS));

  always_comb begin
    rd_word = '0;
    case (reg_addr_i)
      ADDR_CTRL: begin
        rd_word[CTRL_SEL_BIT]     = sel_q;
        rd_word[CTRL_TRIG_EN_BIT] = trig_en_q;
      end
      ADDR_WATERMARK: rd_word = wm_q;
      ADDR_STATUS: begin
        rd_word[7:0]          = 8'(buf_i.count);
        rd_word[STAT_OVF_BIT]  = buf_i.overflow;
        rd_word[STAT_TRIG_BIT] = trig_flag_q;
      end
      ADDR_TRIG_PC: rd_word = trig_pc_q;
      default: begin
        // Head record seen word by word
        if (in_rec) begin
          rd_word = buf_i.head_rec.w[rec_off[4:2]];
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  // --------------------
  // Interrupts
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      trig_flag_q <= 1'b0;
      wm_irq_q    <= 1'b0;
    end else begin
      if (trig_hit_i) begin
        trig_flag_q <= 1'b1;
      end else if (clr_hit && reg_wdata_i[CLR_TRIG_BIT]) begin
        trig_flag_q <= 1'b0;
      end
      wm_irq_q <= (wm_q != '0) && (32'(buf_i.count) >= wm_q);
    end
  end

  assign reg_rdata_o     = rdata_q;
  assign core_sel_o      = sel_q;
  assign trig_en_o       = trig_en_q;
  assign trig_pc_o       = trig_pc_q;
  assign watermark_irq_o = wm_irq_q;
  assign trigger_irq_o   = trig_flag_q;

  a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_en && reg_addr_i == ADDR_POP) |-> (buf_i.count != '0));

endmodule

// File: hw/trace_fifo.sv
// Ring buffer of trace records with fill count and sticky overflow flag
`timescale 1ns/1ns

module trace_fifo
  import cva6_trace_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          ovf_clr_i,
  trace_buf_if.store    buf_i
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  trace_rec_u         mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count_q;
  logic               ovf_q;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count_q == CNT_W'(DEPTH));
  assign do_pop  = buf_i.pop && (count_q != '0);
  // Full buffer still accepts a push when the head leaves in the same cycle
  assign do_push = buf_i.push && (!full || do_pop);

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Sticky until cleared, a new drop wins over a clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ovf_q <= 1'b0;
    end else if (buf_i.push && !do_push) begin
      ovf_q <= 1'b1;
    end else if (ovf_clr_i) begin
      ovf_q <= 1'b0;
    end
  end

  // Record storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= buf_i.push_rec;
    end
  end

  assign buf_i.head_rec = mem[rd_ptr];
  assign buf_i.count    = count_q;
  assign buf_i.overflow = ovf_q;

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    buf_i.pop |-> (count_q != '0));

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CNT_W'(DEPTH));

endmodule

// File: hw/cfi_trace_pack.sv
// Core selection, PC splitting, trigger match and the capture register
`timescale 1ns/1ns

module cfi_trace_pack
  import cva6_trace_pkg::*;
  import snoop_reg_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  src_pc_i,
  input  logic [NUM_CORES-1:0][PC_WIDTH-1:0]  dst_pc_i,
  input  ctr_type_t [NUM_CORES-1:0]           ctr_type_i,
  input  priv_lvl_t [NUM_CORES-1:0]           priv_lvl_i,
  input  logic [NUM_CORES-1:0][31:0]          instr_i,
  input  logic [NUM_CORES-1:0]                pc_valid_i,
  input  logic                                core_sel_i,
  input  logic                                trig_en_i,
  input  reg_data_t                           trig_pc_i,
  output logic                                trig_hit_o,
  trace_buf_if.wr                             buf_o
);

  trace_rec_u rec_d;
  trace_rec_u rec_q;
  logic       sel_valid;
  logic       push_q;
  logic       hit_q;

  assign sel_valid = pc_valid_i[core_sel_i];

  // Split PCs into high and low words, top bit and bit 0 cleared
  always_comb begin
    rec_d            = '0;
    rec_d.f.pc_src_h = {1'b0, src_pc_i[core_sel_i][62:32]};
    rec_d.f.pc_src_l = {src_pc_i[core_sel_i][31:1], 1'b0};
    rec_d.f.pc_dst_h = {1'b0, dst_pc_i[core_sel_i][62:32]};
    rec_d.f.pc_dst_l = {dst_pc_i[core_sel_i][31:1], 1'b0};
    rec_d.f.metadata = 32'(ctr_type_i[core_sel_i]);
    rec_d.f.opcode   = instr_i[core_sel_i];
    rec_d.f.priv     = 32'(priv_lvl_i[core_sel_i]);
  end

  // --------------------
  // Capture stage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      push_q <= 1'b0;
      hit_q  <= 1'b0;
    end else begin
      push_q <= sel_valid;
      hit_q  <= sel_valid && trig_en_i && (rec_d.f.pc_dst_l == trig_pc_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_valid) begin
      rec_q <= rec_d;
    end
  end

  assign buf_o.push     = push_q;
  assign buf_o.push_rec = rec_q;
  assign trig_hit_o     = hit_q;

  // A trigger hit always comes with a record going into the buffer
  a_hit_with_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trig_hit_o |-> buf_o.push);

endmodule

// File: hw/trace_buf_if.sv
// Trace buffer interface with push, store and read modports
`timescale 1ns/1ns

interface trace_buf_if
  import cva6_trace_pkg::*;
#(
  parameter int DEPTH = 8
) ();

  localparam int CNT_W = $clog2(DEPTH + 1);

  // Push side, one record per strobe
  logic                 push;
  trace_rec_u           push_rec;

  // Read side
  logic                 pop;
  trace_rec_u           head_rec;
  logic [CNT_W-1:0]     count;
  logic                 overflow;

  modport wr    (output push, push_rec);
  modport store (input push, push_rec, pop, output head_rec, count, overflow);
  modport rd    (output pop, input head_rec, count, overflow);

endinterface

// File: hw/snoop_reg_pkg.sv
// Register map, register data types and control and status bit positions
package snoop_reg_pkg;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // --------------------
  // Register map
  // --------------------
  localparam reg_addr_t ADDR_CTRL      = 8'h00;
  localparam reg_addr_t ADDR_WATERMARK = 8'h04;
  localparam reg_addr_t ADDR_STATUS    = 8'h08;
  localparam reg_addr_t ADDR_TRIG_PC   = 8'h0C;
  localparam reg_addr_t ADDR_IRQ_CLR   = 8'h10;
  localparam reg_addr_t ADDR_POP       = 8'h14;
  localparam reg_addr_t ADDR_REC_BASE  = 8'h20;

  // Bit positions
  localparam int CTRL_SEL_BIT     = 0;
  localparam int CTRL_TRIG_EN_BIT = 1;
  localparam int STAT_OVF_BIT     = 8;
  localparam int STAT_TRIG_BIT    = 9;
  localparam int CLR_TRIG_BIT     = 0;
  localparam int CLR_OVF_BIT      = 1;

endpackage

// File: hw/cva6_trace_pkg.sv
// Trace field types, record layout and the packed record union
package cva6_trace_pkg;

  // Number of traced cores and their PC width
  localparam int NUM_CORES = 2;
  localparam int PC_WIDTH  = 64;

  // 32-bit words per captured record
  localparam int REC_WORDS = 7;

  typedef logic [1:0] priv_lvl_t;
  typedef logic [3:0] ctr_type_t;

  // --------------------
  // Record layout
  // --------------------

  // Field order matches the register window, pc_src_h is word 0
  typedef struct packed {
    logic [31:0] pc_src_h;
    logic [31:0] pc_src_l;
    logic [31:0] pc_dst_h;
    logic [31:0] pc_dst_l;
    logic [31:0] metadata;
    logic [31:0] opcode;
    logic [31:0] priv;
  } trace_fields_t;

  // Same record seen as named fields or as indexed words
  typedef union packed {
    trace_fields_t                    f;
    logic [0:REC_WORDS-1][31:0]       w;
  } trace_rec_u;

endpackage
